/* common/mul_macros.svh */
`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// Operand and result width
`define MUL_DATA_WIDTH      32

// Instruction address width
`define MUL_PC_WIDTH        32

// Reorder buffer ticket width
`define MUL_ROB_ID_WIDTH    6

// Destination register address width
`define MUL_REG_ADDR_WIDTH  5

// Register stages behind the first pipe register
`define MUL_STAGES          3

// Issue cycle to writeback
`define MUL_LATENCY         (`MUL_STAGES + 1)

`endif

/* common/mul_data_pkg.sv */
`include "mul_macros.svh"

package mul_data_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath values

    // One operand or one result
    typedef logic [`MUL_DATA_WIDTH-1:0]     data_t;

    // Full product, low half is the result
    typedef logic [2*`MUL_DATA_WIDTH-1:0]   product_t;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction metadata

    // Reorder buffer ticket, also the instruction id
    typedef logic [`MUL_ROB_ID_WIDTH-1:0]   rob_id_t;

    typedef logic [`MUL_REG_ADDR_WIDTH-1:0] reg_addr_t;

    typedef logic [`MUL_PC_WIDTH-1:0]       pc_t;

endpackage

/* common/mul_ctrl_pkg.sv */
package mul_ctrl_pkg;

    // Operand gathering FSM
    // IDLE takes requests from decode, WAIT holds one until both
    // operands have shown up
    typedef enum logic
    {
        OPERAND_IDLE,
        OPERAND_WAIT
    } operand_state_e;

endpackage

/* common/mul_issue_if.sv */
`timescale 1ns/1ps

// One issued instruction per cycle, pipe always accepts
interface mul_issue_if
    import mul_data_pkg::*;
();

    logic      valid;
    rob_id_t   instr_id;
    pc_t       pc;
    reg_addr_t rd;

    // Operands as gathered
    data_t     src1;
    data_t     src2;

    modport source
    (
        output valid,
        output instr_id,
        output pc,
        output rd,
        output src1,
        output src2
    );

    modport sink
    (
        input  valid,
        input  instr_id,
        input  pc,
        input  rd,
        input  src1,
        input  src2
    );

endinterface

/* operand/operand_gather.sv */
`timescale 1ns/1ps

module operand_gather
    import mul_data_pkg::*;
    import mul_ctrl_pkg::*;
(
    input  logic        clock,
    input  logic        arst_n,
    input  logic        flush,

    // Request from decode
    input  logic        req_valid,
    input  rob_id_t     req_instr_id,
    input  pc_t         req_pc,
    input  reg_addr_t   req_rd,
    input  logic        req_src1_blocked,
    input  rob_id_t     req_src1_ticket,
    input  data_t       req_src1_data,
    input  logic        req_src2_blocked,
    input  rob_id_t     req_src2_ticket,
    input  data_t       req_src2_data,

    output logic        stall,

    // RoB bypass lookup
    output rob_id_t     rob_src1_id,
    output rob_id_t     rob_src2_id,
    input  logic        rob_src1_hit,
    input  logic        rob_src2_hit,
    input  data_t       rob_src1_data,
    input  data_t       rob_src2_data,

    // Register file write snoop
    input  logic        rf_write_en,
    input  rob_id_t     rf_write_rob_id,
    input  data_t       rf_write_data,

    mul_issue_if.source issue
);

operand_state_e state_q;
operand_state_e state_d;

// Request held while waiting
rob_id_t   instr_id_q;
pc_t       pc_q;
reg_addr_t rd_q;
rob_id_t   ticket1_q;
rob_id_t   ticket2_q;

// Operands already found
logic      found1_q;
logic      found2_q;
data_t     data1_q;
data_t     data2_q;

logic      active;
logic      have1;
logic      have2;
logic      both;
logic      snoop1;
logic      snoop2;
data_t     src1_val;
data_t     src2_val;

////////////////////////////////////////////////////////////////////////////
// Operand selection

always_comb
begin
    if (state_q == OPERAND_WAIT)
    begin
        active      = 1'b1;
        rob_src1_id = ticket1_q;
        rob_src2_id = ticket2_q;
        have1       = found1_q | rob_src1_hit;
        have2       = found2_q | rob_src2_hit;
        src1_val    = found1_q ? data1_q : rob_src1_data;
        src2_val    = found2_q ? data2_q : rob_src2_data;
    end
    else
    begin
        active      = req_valid;
        rob_src1_id = req_src1_ticket;
        rob_src2_id = req_src2_ticket;
        have1       = !req_src1_blocked | rob_src1_hit;
        have2       = !req_src2_blocked | rob_src2_hit;
        src1_val    = req_src1_blocked ? rob_src1_data : req_src1_data;
        src2_val    = req_src2_blocked ? rob_src2_data : req_src2_data;
    end
end

// RF write to the ticket we are looking up
assign snoop1 = rf_write_en & (rf_write_rob_id == rob_src1_id);
assign snoop2 = rf_write_en & (rf_write_rob_id == rob_src2_id);

assign both  = have1 & have2;
assign stall = active & !both;

assign issue.valid    = active & both;
assign issue.instr_id = (state_q == OPERAND_WAIT) ? instr_id_q : req_instr_id;
assign issue.pc       = (state_q == OPERAND_WAIT) ? pc_q : req_pc;
assign issue.rd       = (state_q == OPERAND_WAIT) ? rd_q : req_rd;
assign issue.src1     = src1_val;
assign issue.src2     = src2_val;

////////////////////////////////////////////////////////////////////////////
// Wait FSM

always_comb
begin
    state_d = state_q;
    case (state_q)
        OPERAND_IDLE:
            if (req_valid && !both)
                state_d = OPERAND_WAIT;
        OPERAND_WAIT:
            if (both)
                state_d = OPERAND_IDLE;
        default:
            state_d = OPERAND_IDLE;
    endcase

    // Flush drops the waiting instruction
    if (flush)
        state_d = OPERAND_IDLE;
end

always_ff @(posedge clock or negedge arst_n)
begin
    if (!arst_n)
    begin
        state_q  <= OPERAND_IDLE;
        found1_q <= 1'b0;
        found2_q <= 1'b0;
    end
    else
    begin
        state_q <= state_d;
        if (active)
        begin
            found1_q <= have1 | snoop1;
            found2_q <= have2 | snoop2;
        end
    end
end

// Capture on request, found data held once present
always_ff @(posedge clock)
begin
    if (state_q == OPERAND_IDLE && req_valid)
    begin
        instr_id_q <= req_instr_id;
        pc_q       <= req_pc;
        rd_q       <= req_rd;
        ticket1_q  <= req_src1_ticket;
        ticket2_q  <= req_src2_ticket;
    end
    if (active)
    begin
        data1_q <= have1 ? src1_val : rf_write_data;
        data2_q <= have2 ? src2_val : rf_write_data;
    end
end

// A stalled request is held in the wait state
a_stall_holds_request: assert property (@(posedge clock) disable iff (!arst_n)
    (stall && !flush) |=> (state_q == OPERAND_WAIT));

// An issued instruction is not left waiting to issue again
a_issue_frees_wait: assert property (@(posedge clock) disable iff (!arst_n)
    (issue.valid && !flush) |=> (state_q == OPERAND_IDLE));

endmodule

/* mul_pipe/mul_pipe.sv */
`timescale 1ns/1ps
`include "mul_macros.svh"

module mul_pipe
    import mul_data_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,
    input  logic       flush,

    // Issued instruction
    mul_issue_if.sink  issue,

    // Request to writeback
    output logic       wb_valid,
    output rob_id_t    wb_instr_id,
    output pc_t        wb_pc,
    output reg_addr_t  wb_rd,
    output data_t      wb_data,
    output logic       wb_overflow
);

product_t  product;
logic      overflow;

// Stage 0 is loaded from the issue, the rest shift down
logic      valid_q    [0:`MUL_STAGES];
rob_id_t   instr_id_q [0:`MUL_STAGES];
pc_t       pc_q       [0:`MUL_STAGES];
reg_addr_t rd_q       [0:`MUL_STAGES];
data_t     data_q     [0:`MUL_STAGES];
logic      overflow_q [0:`MUL_STAGES];

////////////////////////////////////////////////////////////////////////////
// Multiply

// Zero extended operands, unsigned product
assign product  = product_t'(issue.src1) * product_t'(issue.src2);

// Any bit above the data width means the result does not fit
assign overflow = |product[2*`MUL_DATA_WIDTH-1:`MUL_DATA_WIDTH];

always_ff @(posedge clock or negedge arst_n)
begin
    if (!arst_n)
        valid_q[0] <= 1'b0;
    else
        valid_q[0] <= issue.valid & !flush;
end

always_ff @(posedge clock)
begin
    instr_id_q[0] <= issue.instr_id;
    pc_q[0]       <= issue.pc;
    rd_q[0]       <= issue.rd;
    data_q[0]     <= product[`MUL_DATA_WIDTH-1:0];
    overflow_q[0] <= overflow;
end

////////////////////////////////////////////////////////////////////////////
// Remaining stages

generate
    for (genvar s = 1; s <= `MUL_STAGES; s++)
    begin : gen_stage
        always_ff @(posedge clock or negedge arst_n)
        begin
            if (!arst_n)
                valid_q[s] <= 1'b0;
            else
                valid_q[s] <= valid_q[s-1] & !flush;
        end

        always_ff @(posedge clock)
        begin
            instr_id_q[s] <= instr_id_q[s-1];
            pc_q[s]       <= pc_q[s-1];
            rd_q[s]       <= rd_q[s-1];
            data_q[s]     <= data_q[s-1];
            overflow_q[s] <= overflow_q[s-1];
        end
    end
endgenerate

////////////////////////////////////////////////////////////////////////////
// Writeback

// A flush this cycle also kills the result leaving now
assign wb_valid    = valid_q[`MUL_STAGES] & !flush;
assign wb_instr_id = instr_id_q[`MUL_STAGES];
assign wb_pc       = pc_q[`MUL_STAGES];
assign wb_rd       = rd_q[`MUL_STAGES];
assign wb_data     = data_q[`MUL_STAGES];
assign wb_overflow = overflow_q[`MUL_STAGES];

a_wb_valid_known: assert property (@(posedge clock) disable iff (!arst_n)
    !$isunknown(wb_valid));

endmodule

/* design/mul_top.sv */
`timescale 1ns/1ps

module mul_top
    import mul_data_pkg::*;
(
    input  logic      clock,
    input  logic      arst_n,
    input  logic      flush,

    // Request from decode
    input  logic      req_valid,
    input  rob_id_t   req_instr_id,
    input  pc_t       req_pc,
    input  reg_addr_t req_rd,
    input  logic      req_src1_blocked,
    input  rob_id_t   req_src1_ticket,
    input  data_t     req_src1_data,
    input  logic      req_src2_blocked,
    input  rob_id_t   req_src2_ticket,
    input  data_t     req_src2_data,

    output logic      stall,

    // RoB bypass
    output rob_id_t   rob_src1_id,
    output rob_id_t   rob_src2_id,
    input  logic      rob_src1_hit,
    input  logic      rob_src2_hit,
    input  data_t     rob_src1_data,
    input  data_t     rob_src2_data,

    // Register file writes seen on the way
    input  logic      rf_write_en,
    input  rob_id_t   rf_write_rob_id,
    input  data_t     rf_write_data,

    // Request to writeback
    output logic      wb_valid,
    output rob_id_t   wb_instr_id,
    output pc_t       wb_pc,
    output reg_addr_t wb_rd,
    output data_t     wb_data,
    output logic      wb_overflow
);

mul_issue_if issue_bus ();

operand_gather i_operand_gather
(
    .clock            (clock),
    .arst_n           (arst_n),
    .flush            (flush),
    .req_valid        (req_valid),
    .req_instr_id     (req_instr_id),
    .req_pc           (req_pc),
    .req_rd           (req_rd),
    .req_src1_blocked (req_src1_blocked),
    .req_src1_ticket  (req_src1_ticket),
    .req_src1_data    (req_src1_data),
    .req_src2_blocked (req_src2_blocked),
    .req_src2_ticket  (req_src2_ticket),
    .req_src2_data    (req_src2_data),
    .stall            (stall),
    .rob_src1_id      (rob_src1_id),
    .rob_src2_id      (rob_src2_id),
    .rob_src1_hit     (rob_src1_hit),
    .rob_src2_hit     (rob_src2_hit),
    .rob_src1_data    (rob_src1_data),
    .rob_src2_data    (rob_src2_data),
    .rf_write_en      (rf_write_en),
    .rf_write_rob_id  (rf_write_rob_id),
    .rf_write_data    (rf_write_data),
    .issue            (issue_bus.source)
);

mul_pipe i_mul_pipe
(
    .clock       (clock),
    .arst_n      (arst_n),
    .flush       (flush),
    .issue       (issue_bus.sink),
    .wb_valid    (wb_valid),
    .wb_instr_id (wb_instr_id),
    .wb_pc       (wb_pc),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .wb_overflow (wb_overflow)
);

endmodule

/* bench/mul_tests.svh */
`ifndef MUL_TESTS_SVH
`define MUL_TESTS_SVH

////////////////////////////////////////////////////////////////////////////
// Reporting and compares

task automatic report_failure(string what);
    $display("%0t ns: %s", $time, what);
    error_count++;
endtask

task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
    $display("error at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
    error_count++;
endtask

task automatic check_data(string name, data_t expected, data_t actual);
    check_count++;
    if (actual !== expected)
        report_mismatch(name, expected, actual);
endtask

task automatic check_pc(string name, pc_t expected, pc_t actual);
    check_count++;
    if (actual !== expected)
        report_mismatch(name, expected, actual);
endtask

task automatic check_rob_id(string name, rob_id_t expected, rob_id_t actual);
    check_count++;
    if (actual !== expected)
        report_mismatch(name, expected, actual);
endtask

task automatic check_reg_addr(string name, reg_addr_t expected, reg_addr_t actual);
    check_count++;
    if (actual !== expected)
        report_mismatch(name, expected, actual);
endtask

task automatic check_flag(string name, logic expected, logic actual);
    check_count++;
    if (actual !== expected)
        report_mismatch(name, expected, actual);
endtask

// Oldest expected result against the one leaving now
task automatic compare_writeback();
    expect_t e;
    if (exp_q.size() == 0)
    begin
        report_failure($sformatf("unexpected writeback for id %0d", wb_instr_id));
    end
    else
    begin
        e = exp_q.pop_front();
        check_rob_id("wb_instr_id", e.instr_id, wb_instr_id);
        check_pc("wb_pc", e.pc, wb_pc);
        check_reg_addr("wb_rd", e.rd, wb_rd);
        check_data("wb_data", e.data, wb_data);
        check_flag("wb_overflow", e.overflow, wb_overflow);
        if (cycle_count != e.cycle + `MUL_LATENCY)
            report_failure($sformatf("result for id %0d came in cycle %0d, not %0d",
                e.instr_id, cycle_count, e.cycle + `MUL_LATENCY));
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Stimulus helpers, all called on the falling edge

function automatic void expect_result(rob_id_t id, pc_t pc, reg_addr_t rd,
                                      data_t a, data_t b, int cycle);
    expect_t e;
    data_t   max_val;
    max_val    = '1;
    e.instr_id = id;
    e.pc       = pc;
    e.rd       = rd;
    // Result wraps at the data width
    e.data     = a * b;
    // Too big when a exceeds the largest value divided by b
    e.overflow = (b != '0) && (a > max_val / b);
    e.cycle    = cycle;
    exp_q.push_back(e);
endfunction

task automatic set_request(rob_id_t id, pc_t pc, reg_addr_t rd,
                           logic b1, rob_id_t t1, data_t d1,
                           logic b2, rob_id_t t2, data_t d2);
    req_valid        = 1'b1;
    req_instr_id     = id;
    req_pc           = pc;
    req_rd           = rd;
    req_src1_blocked = b1;
    req_src1_ticket  = t1;
    req_src1_data    = d1;
    req_src2_blocked = b2;
    req_src2_ticket  = t2;
    req_src2_data    = d2;
endtask

task automatic drive_idle();
    set_request('0, '0, '0, 1'b0, '0, '0, 1'b0, '0, '0);
    req_valid       = 1'b0;
    flush           = 1'b0;
    rf_write_en     = 1'b0;
    rf_write_rob_id = '0;
    rf_write_data   = '0;
endtask

task automatic clear_rob();
    for (int i = 0; i < ROB_SIZE; i++)
    begin
        rob_ready[i] = 1'b0;
        rob_value[i] = '0;
    end
endtask

// One cycle request with both operands in hand
task automatic send_ready(rob_id_t id, pc_t pc, reg_addr_t rd, data_t a, data_t b, bit live);
    set_request(id, pc, rd, 1'b0, '0, a, 1'b0, '0, b);
    if (live)
        expect_result(id, pc, rd, a, b, cycle_count);
    @(posedge clock);
    check_flag("stall", 1'b0, stall);
    @(negedge clock);
    req_valid = 1'b0;
endtask

task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < `MUL_LATENCY + 2)
    begin
        @(negedge clock);
        waited++;
    end
    if (exp_q.size() != 0)
    begin
        report_failure($sformatf("%0d results never reached writeback", exp_q.size()));
        exp_q.delete();
    end
    // Quiet cycles so a stray late result is still seen
    repeat (`MUL_LATENCY) @(negedge clock);
endtask

task automatic finish_test(string name, int errors_before);
    test_count++;
    $display("%0t ns: %s finished, %0d errors", $time, name, error_count - errors_before);
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests

task automatic test_ready_operands();
    int errors_before;
    errors_before = error_count;
    send_ready(6'd1, 32'h0000_1000, 5'd3, 32'd1234, 32'd5678, 1'b1);
    wait_drain();
    finish_test("ready operands", errors_before);
endtask

task automatic test_overflow();
    int errors_before;
    errors_before = error_count;
    // Fits, just over, far over, small
    send_ready(6'd2, 32'h0000_2000, 5'd4, 32'h0000_ffff, 32'h0001_0001, 1'b1);
    send_ready(6'd3, 32'h0000_2004, 5'd5, 32'h0001_0000, 32'h0001_0000, 1'b1);
    send_ready(6'd4, 32'h0000_2008, 5'd6, 32'hffff_ffff, 32'h0000_0002, 1'b1);
    send_ready(6'd5, 32'h0000_200c, 5'd7, 32'd7, 32'd9, 1'b1);
    wait_drain();
    finish_test("overflow", errors_before);
endtask

task automatic test_rob_bypass();
    int errors_before;
    errors_before = error_count;
    rob_ready[10] = 1'b1;
    rob_value[10] = 32'h0000_1111;
    rob_ready[11] = 1'b1;
    rob_value[11] = 32'h0000_0202;
    set_request(6'd30, 32'h0000_3000, 5'd8, 1'b1, 6'd10, 32'd7, 1'b1, 6'd11, 32'd9);
    expect_result(6'd30, 32'h0000_3000, 5'd8, 32'h0000_1111, 32'h0000_0202, cycle_count);
    @(posedge clock);
    check_rob_id("rob_src1_id", 6'd10, rob_src1_id);
    check_rob_id("rob_src2_id", 6'd11, rob_src2_id);
    check_flag("stall", 1'b0, stall);
    @(negedge clock);
    req_valid = 1'b0;
    clear_rob();
    wait_drain();
    finish_test("rob bypass", errors_before);
endtask

task automatic test_waiting();
    int    errors_before;
    data_t a;
    data_t b;
    errors_before = error_count;
    a = 32'h0001_2345;
    b = 32'h0000_0321;
    set_request(6'd40, 32'h0000_4000, 5'd9, 1'b1, 6'd20, 32'hdead_0001,
                1'b1, 6'd21, 32'hdead_0002);
    @(posedge clock);
    check_flag("stall", 1'b1, stall);
    @(negedge clock);
    req_valid     = 1'b0;
    // src1 turns up in the RoB
    rob_ready[20] = 1'b1;
    rob_value[20] = a;
    @(posedge clock);
    check_rob_id("rob_src1_id", 6'd20, rob_src1_id);
    check_flag("stall", 1'b1, stall);
    @(negedge clock);
    rob_ready[20]   = 1'b0;
    rf_write_en     = 1'b1;
    rf_write_rob_id = 6'd22;
    rf_write_data   = 32'hbad0_bad0;
    @(posedge clock);
    check_flag("stall", 1'b1, stall);
    @(negedge clock);
    // Matching write, used one cycle later
    rf_write_rob_id = 6'd21;
    rf_write_data   = b;
    expect_result(6'd40, 32'h0000_4000, 5'd9, a, b, cycle_count + 1);
    @(posedge clock);
    check_flag("stall", 1'b1, stall);
    @(negedge clock);
    rf_write_en = 1'b0;
    @(posedge clock);
    check_flag("stall", 1'b0, stall);
    @(negedge clock);
    wait_drain();
    finish_test("waiting operands", errors_before);
endtask

task automatic test_flush();
    int errors_before;
    errors_before = error_count;
    send_ready(6'd50, 32'h0000_5000, 5'd10, 32'd3, 32'd5, 1'b0);
    send_ready(6'd51, 32'h0000_5004, 5'd11, 32'd4, 32'd6, 1'b0);
    send_ready(6'd52, 32'h0000_5008, 5'd12, 32'd5, 32'd7, 1'b0);
    set_request(6'd53, 32'h0000_500c, 5'd13, 1'b1, 6'd31, '0, 1'b1, 6'd31, '0);
    @(posedge clock);
    check_flag("stall", 1'b1, stall);
    @(negedge clock);
    req_valid = 1'b0;
    flush     = 1'b1;
    @(negedge clock);
    flush = 1'b0;
    @(posedge clock);
    check_flag("stall", 1'b0, stall);
    @(negedge clock);
    repeat (`MUL_LATENCY) @(negedge clock);
    send_ready(6'd54, 32'h0000_5010, 5'd14, 32'd11, 32'd13, 1'b1);
    wait_drain();
    finish_test("flush", errors_before);
endtask

task automatic test_stream();
    int    errors_before;
    int    max_in_flight;
    data_t a;
    data_t b;
    errors_before = error_count;
    max_in_flight = 0;
    for (int i = 0; i < STREAM_LENGTH; i++)
    begin
        a = next_random();
        b = (i % 2 == 0) ? next_random() : (next_random() >> 16);
        send_ready(rob_id_t'(i), pc_t'(next_random() & ~32'h3), reg_addr_t'(i), a, b, 1'b1);
        if (exp_q.size() > max_in_flight)
            max_in_flight = exp_q.size();
    end
    if (max_in_flight < 2)
        report_failure("the stream never had more than one instruction in flight");
    wait_drain();
    finish_test("pipelined stream", errors_before);
endtask

`endif

/* bench/tb_mul_top.sv */
`timescale 1ns/1ps
`include "mul_macros.svh"

module tb_mul_top
    import mul_data_pkg::*;
();

localparam int CLOCK_PERIOD  = 100;
localparam int RESET_CYCLES  = 16;
localparam int STREAM_LENGTH = 16;
localparam int ROB_SIZE      = 2**`MUL_ROB_ID_WIDTH;

// Rough sum of all test lengths in cycles
localparam int TEST_CYCLES   = 100;
localparam int MARGIN_CYCLES = 100;

// One result the monitor waits for
typedef struct packed
{
    rob_id_t   instr_id;
    pc_t       pc;
    reg_addr_t rd;
    data_t     data;
    logic      overflow;
    int        cycle;
} expect_t;

logic      clock;
logic      arst_n;
logic      flush;
logic      req_valid;
rob_id_t   req_instr_id;
pc_t       req_pc;
reg_addr_t req_rd;
logic      req_src1_blocked;
rob_id_t   req_src1_ticket;
data_t     req_src1_data;
logic      req_src2_blocked;
rob_id_t   req_src2_ticket;
data_t     req_src2_data;
logic      stall;
rob_id_t   rob_src1_id;
rob_id_t   rob_src2_id;
logic      rob_src1_hit;
logic      rob_src2_hit;
data_t     rob_src1_data;
data_t     rob_src2_data;
logic      rf_write_en;
rob_id_t   rf_write_rob_id;
data_t     rf_write_data;
logic      wb_valid;
rob_id_t   wb_instr_id;
pc_t       wb_pc;
reg_addr_t wb_rd;
data_t     wb_data;
logic      wb_overflow;

// RoB model, entries filled by the tests
logic      rob_ready [0:ROB_SIZE-1];
data_t     rob_value [0:ROB_SIZE-1];

expect_t   exp_q [$];
int        cycle_count = 0;
int        check_count = 0;
int        error_count = 0;
int        test_count  = 0;
logic [31:0] lcg_state = 32'hb120;

mul_top i_dut (.*);

assign rob_src1_hit  = rob_ready[rob_src1_id];
assign rob_src2_hit  = rob_ready[rob_src2_id];
assign rob_src1_data = rob_value[rob_src1_id];
assign rob_src2_data = rob_value[rob_src2_id];

function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

`include "mul_tests.svh"

initial
begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
end

////////////////////////////////////////////////////////////////////////////
// Writeback monitor, cycle numbers advance here

always @(posedge clock)
begin
    if (arst_n && wb_valid)
        compare_writeback();
    cycle_count++;
end

initial
begin
    #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLOCK_PERIOD);
    $display("Timeout: the tests did not finish in time");
    $display("Test FAILED");
    $finish;
end

initial
begin
    clear_rob();
    drive_idle();
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clock);
    arst_n = 1'b1;
    @(negedge clock);
    test_ready_operands();
    test_overflow();
    test_rob_bypass();
    test_waiting();
    test_flush();
    test_stream();
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0)
        $display("Test OK");
    else
        $display("Test FAILED");
    $finish;
end

endmodule

/* verilog.f */
+incdir+common
+incdir+bench
common/mul_data_pkg.sv
common/mul_ctrl_pkg.sv
common/mul_issue_if.sv
operand/operand_gather.sv
mul_pipe/mul_pipe.sv
design/mul_top.sv
bench/tb_mul_top.sv
